/* sim.f */
hdl/terminal_pkg.sv
hdl/terminal_router.sv
hdl/dram_port_bridge.sv
hdl/dram_status_regs.sv
hdl/terminal_host_top.sv
bench/terminal_host_sva.sv
bench/mem_port_model.sv
bench/host_checker.sv
bench/tb_terminal_host.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the terminal host testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_terminal_host --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test failures found" sim.log; then
   exit 1
fi
exit 0

/* bench/tb_terminal_host.sv */
// Testbench for the host register path
// Clock, reset, LCG driven host transfers, timeout and final summary
`timescale 1ns/10ps
`default_nettype none

module tb_terminal_host;

   localparam int TXN_TOTAL   = 44 + 16 + 10 + 24 + 8 + 30;
   localparam int CYCLE_LIMIT = 200 * TXN_TOTAL;

   logic        ifclk = 1'b0;
   logic        rst_n = 1'b0;
   logic        calib_done = 1'b0;
   logic        inj_wr_error = 1'b0;
   logic        inj_rd_overflow = 1'b0;
   logic [6:0]  stall_pct = 7'd0;
   logic [31:0] rng_state = 32'd5080;
   logic [31:0] addr_list [8];
   int          cycles = 0;

   terminal_pkg::host_req_t   host_req = '0;
   terminal_pkg::host_rsp_t   host_rsp;
   terminal_pkg::mem_cmd_t    mem_cmd;
   terminal_pkg::mem_status_t mem_status;

   always #50 ifclk = ~ifclk;

   terminal_host_top #(.MEM_BASE_ADDR(30'h1000)) terminal_host_top_inst (
      .ifclk (ifclk), .rst_n (rst_n), .host_req (host_req), .host_rsp (host_rsp),
      .mem_cmd (mem_cmd), .mem_status (mem_status), .calib_done (calib_done)
   );

   mem_port_model mem_port_model_inst (
      .ifclk (ifclk), .rst_n (rst_n), .mem_cmd (mem_cmd), .mem_status (mem_status),
      .stall_pct (stall_pct), .inj_wr_error (inj_wr_error),
      .inj_rd_overflow (inj_rd_overflow)
   );

   host_checker checker_inst (
      .ifclk (ifclk), .rst_n (rst_n), .calib_done (calib_done), .host_req (host_req),
      .host_rsp (host_rsp), .mem_cmd (mem_cmd), .mem_status (mem_status)
   );

   always @(posedge ifclk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: no finish after %0d cycles, a transfer never completed", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   function logic [15:0] rand16();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state[30:15];
   endfunction

   // One host transfer, held until rdy, then strobes dropped
   task automatic transfer(input logic [15:0] term, input logic [31:0] addr,
                           input logic wr, input logic [31:0] data);
      host_req.term_addr = term;
      host_req.reg_addr  = addr;
      host_req.data      = data;
      host_req.write     = wr;
      host_req.read      = !wr;
      do @(negedge ifclk); while (!host_rsp.rdy);
      @(posedge ifclk);
      #1;
      host_req.read  = 1'b0;
      host_req.write = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge ifclk);
      #1;
   endtask

   task automatic random_dram(input int n);
      logic [15:0] r;
      repeat (n) begin
         r = rand16();
         transfer(terminal_pkg::TERM_DRAM, {28'd0, r[3:0]}, r[8], {rand16(), rand16()});
      end
   endtask

   initial begin
      wait_cycles(3);
      rst_n = 1'b1;
      wait_cycles(1);

      stall_pct = 7'd25;
      for (int i = 0; i < 4; i++) transfer(terminal_pkg::TERM_DRAM, 32'd40 + i, 1'b0, '0);
      random_dram(40);
      checker_inst.report_test("dram_write_read");

      for (int i = 0; i < 8; i++) begin
         addr_list[i] = {rand16(), rand16()} & 32'h0FFF_FFFF;
         transfer(terminal_pkg::TERM_DRAM, addr_list[i], 1'b1, {rand16(), rand16()});
      end
      for (int i = 0; i < 8; i++) transfer(terminal_pkg::TERM_DRAM, addr_list[i], 1'b0, '0);
      checker_inst.report_test("mem_address");

      for (int i = 0; i < 4; i++) transfer(terminal_pkg::TERM_DUMMY, i, 1'b0, '0);
      transfer(16'd0, 32'd0, 1'b0, '0);
      for (int i = 0; i < 3; i++) transfer(16'd4 + rand16(), i, 1'b0, '0);
      transfer(16'hFFFF, 32'd1, 1'b1, 32'h1234_5678);
      transfer(16'd7, 32'd0, 1'b1, 32'h0000_0006);
      checker_inst.report_test("dummy_terminal");

      for (int i = 0; i < 6; i++) begin
         transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd1, 1'b1, {rand16(), rand16()});
         transfer(terminal_pkg::TERM_DRAM, 32'd1, 1'b1, {rand16(), rand16()});
         transfer(terminal_pkg::TERM_DUMMY, 32'd1, 1'b1, {rand16(), rand16()});
         transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd1, 1'b0, '0);
      end
      checker_inst.report_test("scratch_register");

      inj_wr_error = 1'b1;
      wait_cycles(1);
      inj_wr_error = 1'b0;
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b1, 32'd2);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      inj_rd_overflow = 1'b1;
      wait_cycles(1);
      inj_rd_overflow = 1'b0;
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b1, 32'd4);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      calib_done = 1'b1;
      wait_cycles(2);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      calib_done = 1'b0;
      wait_cycles(2);
      transfer(terminal_pkg::TERM_DRAM_CTRL, 32'd0, 1'b0, '0);
      checker_inst.report_test("status_flags");

      stall_pct = 7'd80;
      random_dram(30);
      stall_pct = 7'd0;
      checker_inst.report_test("back_pressure");

      $display("Totals: %0d tests, %0d failed, %0d checks, %0d mismatches",
               checker_inst.tests, checker_inst.tests_failed,
               checker_inst.total_checks, checker_inst.total_errors);
      if (checker_inst.tests_failed == 0 && checker_inst.total_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bench/host_checker.sv */
// Reference model and checker for the host register path
// Shadow memory, scratch register and status flags
// Per-test result lines and running totals
`timescale 1ns/10ps
`default_nettype none

module host_checker (
   input wire                            ifclk,
   input wire                            rst_n,
   input wire                            calib_done,
   input wire terminal_pkg::host_req_t   host_req,
   input wire terminal_pkg::host_rsp_t   host_rsp,
   input wire terminal_pkg::mem_cmd_t    mem_cmd,
   input wire terminal_pkg::mem_status_t mem_status
);

   logic [31:0] shadow_mem [logic [31:0]];
   logic [31:0] sh_scratch;
   logic        sh_calib;
   logic        sh_wr_err;
   logic        sh_rd_ovf;
   logic [29:0] exp_addr;
   int checks = 0;
   int errors = 0;
   int total_checks = 0;
   int total_errors = 0;
   int tests = 0;
   int tests_failed = 0;

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   function logic [31:0] expected_read();
      case (host_req.term_addr)
         16'd1: return shadow_mem.exists(host_req.reg_addr) ? shadow_mem[host_req.reg_addr] : '0;
         16'd2: begin
            if (host_req.reg_addr == 32'd0) return {29'd0, sh_rd_ovf, sh_wr_err, sh_calib};
            if (host_req.reg_addr == 32'd1) return sh_scratch;
            return '0;
         end
         16'd3: return 32'hBBAA9988;
         default: return '0;
      endcase
   endfunction

   always @(negedge ifclk) begin
      if (!rst_n) begin
         shadow_mem.delete();
         sh_scratch = '0;
         sh_calib   = 1'b0;
         sh_wr_err  = 1'b0;
         sh_rd_ovf  = 1'b0;
      end else begin
         // Byte address is base plus four bytes per register
         exp_addr = 30'(32'h1000 + host_req.reg_addr * 32'd4);
         if (mem_cmd.cmd_en) begin
            check({2'b00, mem_cmd.byte_addr}, {2'b00, exp_addr}, "command address");
            check({29'd0, mem_cmd.instr}, host_req.write ? 32'd0 : 32'd1, "command instr");
         end
         if (mem_cmd.wr_en) check(mem_cmd.wr_data, host_req.data, "write data");
         if (mem_cmd.rd_en) begin
            check({31'd0, host_req.read && (host_req.term_addr == 16'd1)}, 32'd1,
                  "read pop without a DRAM read");
         end
         // Terminals other than the DRAM answer in the strobe cycle
         if ((host_req.read || host_req.write) && host_req.term_addr != 16'd1) begin
            check({31'd0, host_rsp.rdy}, 32'd1, "zero-wait rdy");
         end
         if (host_rsp.rdy && host_req.read) begin
            check(host_rsp.data, expected_read(), "read data");
         end else if (host_rsp.rdy && host_req.write) begin
            if (host_req.term_addr == 16'd1) shadow_mem[host_req.reg_addr] = host_req.data;
            if (host_req.term_addr == 16'd2 && host_req.reg_addr == 32'd1)
               sh_scratch = host_req.data;
            if (host_req.term_addr == 16'd2 && host_req.reg_addr == 32'd0) begin
               sh_wr_err = sh_wr_err & ~host_req.data[1];
               sh_rd_ovf = sh_rd_ovf & ~host_req.data[2];
            end
         end
         // New errors win over a clear in the same cycle
         sh_wr_err = sh_wr_err | mem_status.wr_error;
         sh_rd_ovf = sh_rd_ovf | mem_status.rd_overflow;
         sh_calib  = calib_done;
      end
   end

   task automatic report_test(input string name);
      tests++;
      if (errors != 0) tests_failed++;
      $display("test %-18s %0d checks, %0d mismatches, %s", name, checks, errors,
               (errors == 0) ? "ok" : "FAILED");
      total_checks += checks;
      total_errors += errors;
      checks = 0;
      errors = 0;
   endtask

endmodule

`default_nettype wire

/* bench/mem_port_model.sv */
// Behavioural memory controller port
// Word store by byte address, random back-pressure and read latency
// Error flags passed through from the testbench
`timescale 1ns/10ps
`default_nettype none

module mem_port_model #(
   parameter logic [31:0] SEED = 32'd5080
) (
   input  wire                            ifclk,
   input  wire                            rst_n,
   input  wire terminal_pkg::mem_cmd_t    mem_cmd,
   output terminal_pkg::mem_status_t      mem_status,
   input  wire [6:0]                      stall_pct,
   input  wire                            inj_wr_error,
   input  wire                            inj_rd_overflow
);

   logic [31:0] mem [logic [29:0]];
   logic [31:0] wr_q [$];
   logic [31:0] rd_q [$];
   logic [31:0] rng = SEED;
   logic [2:0]  lat;
   logic        cmd_full_r;
   logic        wr_full_r;
   logic        rd_empty_r;
   logic [31:0] rd_data_r;

   // Percentile roll, 0 to 99
   function logic [6:0] roll();
      rng = rng * 32'd1103515245 + 32'd12345;
      return rng[22:16] % 7'd100;
   endfunction

   always @(posedge ifclk) begin
      logic [6:0] r;
      if (!rst_n) begin
         wr_q.delete();
         rd_q.delete();
         lat        <= 3'd0;
         cmd_full_r <= 1'b0;
         wr_full_r  <= 1'b0;
         rd_empty_r <= 1'b1;
         rd_data_r  <= '0;
      end else begin
         if (mem_cmd.wr_en) wr_q.push_back(mem_cmd.wr_data);
         if (mem_cmd.rd_en && rd_q.size() > 0) void'(rd_q.pop_front());
         if (mem_cmd.cmd_en && mem_cmd.instr == terminal_pkg::MEM_INSTR_WRITE
             && wr_q.size() > 0) begin
            mem[mem_cmd.byte_addr] = wr_q.pop_front();
         end
         if (mem_cmd.cmd_en && mem_cmd.instr == terminal_pkg::MEM_INSTR_READ) begin
            rd_q.push_back(mem.exists(mem_cmd.byte_addr) ? mem[mem_cmd.byte_addr] : '0);
            r = roll();
            lat <= {1'b0, r[1:0]} + 3'd1;
         end else if (lat != 3'd0) begin
            lat <= lat - 3'd1;
         end
         cmd_full_r <= (roll() < stall_pct);
         wr_full_r  <= (roll() < stall_pct);
         rd_empty_r <= (rd_q.size() == 0) || (lat != 3'd0) || (roll() < stall_pct);
         rd_data_r  <= (rd_q.size() > 0) ? rd_q[0] : '0;
      end
   end

   always_comb begin
      mem_status.cmd_full    = cmd_full_r;
      mem_status.wr_full     = wr_full_r;
      mem_status.rd_empty    = rd_empty_r;
      mem_status.rd_data     = rd_data_r;
      mem_status.wr_error    = inj_wr_error;
      mem_status.rd_overflow = inj_rd_overflow;
   end

endmodule

`default_nettype wire

/* bench/terminal_host_sva.sv */
// Concurrent assertions on the DRAM port bridge
// Bound into every dram_port_bridge instance
`timescale 1ns/10ps
`default_nettype none

module terminal_host_sva (
   input wire                            ifclk,
   input wire                            rst_n,
   input wire terminal_pkg::host_req_t   req,
   input wire terminal_pkg::host_rsp_t   rsp,
   input wire terminal_pkg::mem_cmd_t    mem_cmd,
   input wire terminal_pkg::mem_status_t mem_status
);

   a_cmd_wr_excl: assert property (@(posedge ifclk) disable iff (!rst_n)
      !(mem_cmd.cmd_en && mem_cmd.wr_en))
      else $error("cmd_en and wr_en issued in the same cycle");

   a_wr_not_full: assert property (@(posedge ifclk) disable iff (!rst_n)
      mem_cmd.wr_en |-> !mem_status.wr_full)
      else $error("wr_en issued while wr_full is high");

   a_rd_not_empty: assert property (@(posedge ifclk) disable iff (!rst_n)
      mem_cmd.rd_en |-> !mem_status.rd_empty)
      else $error("rd_en issued while rd_empty is high");

   a_rdy_strobe: assert property (@(posedge ifclk) disable iff (!rst_n)
      rsp.rdy |-> (req.read || req.write))
      else $error("rdy high without a host strobe");

endmodule

bind dram_port_bridge terminal_host_sva terminal_host_sva_inst (
   .ifclk      (ifclk),
   .rst_n      (rst_n),
   .req        (req),
   .rsp        (rsp),
   .mem_cmd    (mem_cmd),
   .mem_status (mem_status)
);

`default_nettype wire

/* hdl/terminal_host_top.sv */
// Host register path top level
// Terminal router, DRAM port bridge and DRAM control registers
// Memory controller port is brought out as ports
`timescale 1ns/10ps
`default_nettype none

module terminal_host_top #(
   parameter logic [terminal_pkg::MEM_ADDR_W-1:0] MEM_BASE_ADDR = '0
) (
   input  wire                            ifclk,
   input  wire                            rst_n,
   input  wire terminal_pkg::host_req_t   host_req,
   output terminal_pkg::host_rsp_t        host_rsp,
   output terminal_pkg::mem_cmd_t         mem_cmd,
   input  wire terminal_pkg::mem_status_t mem_status,
   input  wire                            calib_done
);

   terminal_pkg::host_req_t dram_req;
   terminal_pkg::host_rsp_t dram_rsp;
   terminal_pkg::host_req_t ctrl_req;
   terminal_pkg::host_rsp_t ctrl_rsp;

   terminal_router terminal_router_inst (
      .host_req (host_req),
      .host_rsp (host_rsp),
      .dram_req (dram_req),
      .dram_rsp (dram_rsp),
      .ctrl_req (ctrl_req),
      .ctrl_rsp (ctrl_rsp)
   );

   dram_port_bridge #(
      .MEM_BASE_ADDR (MEM_BASE_ADDR)
   ) dram_port_bridge_inst (
      .ifclk      (ifclk),
      .rst_n      (rst_n),
      .req        (dram_req),
      .rsp        (dram_rsp),
      .mem_cmd    (mem_cmd),
      .mem_status (mem_status)
   );

   // Shares the port status with the bridge for the error flags
   dram_status_regs dram_status_regs_inst (
      .ifclk      (ifclk),
      .rst_n      (rst_n),
      .req        (ctrl_req),
      .rsp        (ctrl_rsp),
      .mem_status (mem_status),
      .calib_done (calib_done)
   );

endmodule

`default_nettype wire

/* hdl/dram_status_regs.sv */
// DRAM control terminal registers
// Status word: registered calib_done, sticky wr_error and rd_overflow
// 32-bit scratch register
`timescale 1ns/10ps
`default_nettype none

module dram_status_regs (
   input  wire                            ifclk,
   input  wire                            rst_n,
   input  wire terminal_pkg::host_req_t   req,
   output terminal_pkg::host_rsp_t        rsp,
   input  wire terminal_pkg::mem_status_t mem_status,
   input  wire                            calib_done
);

   localparam logic [terminal_pkg::REG_W-1:0] REG_STATUS  = 32'd0;
   localparam logic [terminal_pkg::REG_W-1:0] REG_SCRATCH = 32'd1;

   logic                            calib_q;
   logic                            wr_error_q;
   logic                            rd_overflow_q;
   logic [terminal_pkg::DATA_W-1:0] scratch;
   logic                            status_wr;

   assign status_wr = req.write && (req.reg_addr == REG_STATUS);

   always_ff @(posedge ifclk) begin
      if (!rst_n) begin
         calib_q       <= 1'b0;
         wr_error_q    <= 1'b0;
         rd_overflow_q <= 1'b0;
         scratch       <= '0;
      end else begin
         calib_q <= calib_done;
         // Write one to clear, a new error in the same cycle wins
         wr_error_q    <= (wr_error_q & ~(status_wr & req.data[1]))
                        | mem_status.wr_error;
         rd_overflow_q <= (rd_overflow_q & ~(status_wr & req.data[2]))
                        | mem_status.rd_overflow;
         if (req.write && (req.reg_addr == REG_SCRATCH)) begin
            scratch <= req.data;
         end
      end
   end

   // Zero-wait terminal
   always_comb begin
      rsp.rdy = req.read | req.write;
      case (req.reg_addr)
         REG_STATUS:  rsp.data = {29'd0, rd_overflow_q, wr_error_q, calib_q};
         REG_SCRATCH: rsp.data = scratch;
         default:     rsp.data = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/dram_port_bridge.sv */
// Host to memory controller port bridge
// Single-word writes as a write-data push then a write command
// Single-word reads as a read command, a data wait and a pop
// Stalls on cmd_full, wr_full and rd_empty
`timescale 1ns/10ps
`default_nettype none

module dram_port_bridge #(
   parameter logic [terminal_pkg::MEM_ADDR_W-1:0] MEM_BASE_ADDR = '0
) (
   input  wire                              ifclk,
   input  wire                              rst_n,
   input  wire terminal_pkg::host_req_t     req,
   output terminal_pkg::host_rsp_t          rsp,
   output terminal_pkg::mem_cmd_t           mem_cmd,
   input  wire terminal_pkg::mem_status_t   mem_status
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_PUSH,
      ST_WR_CMD,
      ST_RD_CMD,
      ST_RD_WAIT,
      ST_RD_DONE
   } state_t;

   state_t state;
   state_t state_nxt;

   logic [terminal_pkg::MEM_ADDR_W-1:0] mem_addr;
   logic [terminal_pkg::DATA_W-1:0]     rd_word;

   // Register address counts 32-bit words
   assign mem_addr = MEM_BASE_ADDR
                   + {req.reg_addr[terminal_pkg::MEM_ADDR_W-3:0], 2'b00};

   always_ff @(posedge ifclk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Read word held until the host takes it
   always_ff @(posedge ifclk) begin
      if (mem_cmd.rd_en) begin
         rd_word <= mem_status.rd_data;
      end
   end

   always_comb begin
      state_nxt         = state;
      mem_cmd           = '0;
      mem_cmd.byte_addr = mem_addr;
      mem_cmd.wr_data   = req.data;
      mem_cmd.instr     = terminal_pkg::MEM_INSTR_WRITE;
      rsp.rdy           = 1'b0;
      rsp.data          = rd_word;

      case (state)
         ST_IDLE: begin
            if (req.write) begin
               state_nxt = ST_WR_PUSH;
            end else if (req.read) begin
               state_nxt = ST_RD_CMD;
            end
         end

         // Data goes in first so the command never runs ahead of it
         ST_WR_PUSH: begin
            if (!mem_status.cmd_full && !mem_status.wr_full) begin
               mem_cmd.wr_en = 1'b1;
               state_nxt     = ST_WR_CMD;
            end
         end

         ST_WR_CMD: begin
            if (!mem_status.cmd_full) begin
               mem_cmd.cmd_en = 1'b1;
               rsp.rdy        = 1'b1;
               state_nxt      = ST_IDLE;
            end
         end

         ST_RD_CMD: begin
            mem_cmd.instr = terminal_pkg::MEM_INSTR_READ;
            if (!mem_status.cmd_full) begin
               mem_cmd.cmd_en = 1'b1;
               state_nxt      = ST_RD_WAIT;
            end
         end

         ST_RD_WAIT: begin
            if (!mem_status.rd_empty) begin
               mem_cmd.rd_en = 1'b1;
               state_nxt     = ST_RD_DONE;
            end
         end

         ST_RD_DONE: begin
            rsp.rdy   = 1'b1;
            state_nxt = ST_IDLE;
         end

         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/terminal_router.sv */
// Host terminal router
// Decodes the terminal address and gates the strobes per terminal
// Selects the addressed terminal's response
// Answers the dummy terminal and unknown terminals locally
`timescale 1ns/10ps
`default_nettype none

module terminal_router (
   input  wire terminal_pkg::host_req_t host_req,
   output terminal_pkg::host_rsp_t      host_rsp,

   output terminal_pkg::host_req_t      dram_req,
   input  wire terminal_pkg::host_rsp_t dram_rsp,

   output terminal_pkg::host_req_t      ctrl_req,
   input  wire terminal_pkg::host_rsp_t ctrl_rsp
);

   logic is_dram;
   logic is_ctrl;
   logic is_dummy;
   logic strobe;

   assign is_dram  = (host_req.term_addr == terminal_pkg::TERM_DRAM);
   assign is_ctrl  = (host_req.term_addr == terminal_pkg::TERM_DRAM_CTRL);
   assign is_dummy = (host_req.term_addr == terminal_pkg::TERM_DUMMY);
   assign strobe   = host_req.read | host_req.write;

   // Address and data go to every terminal, strobes only to the match
   always_comb begin
      dram_req       = host_req;
      dram_req.read  = host_req.read & is_dram;
      dram_req.write = host_req.write & is_dram;
   end

   always_comb begin
      ctrl_req       = host_req;
      ctrl_req.read  = host_req.read & is_ctrl;
      ctrl_req.write = host_req.write & is_ctrl;
   end

   // Response select
   always_comb begin
      if (is_dram) begin
         host_rsp = dram_rsp;
      end else if (is_ctrl) begin
         host_rsp = ctrl_rsp;
      end else if (is_dummy) begin
         host_rsp.rdy  = strobe;
         host_rsp.data = terminal_pkg::DUMMY_WORD;
      end else begin
         // Unknown terminal, zero data and no wait
         host_rsp.rdy  = strobe;
         host_rsp.data = '0;
      end
   end

endmodule

`default_nettype wire

/* hdl/terminal_pkg.sv */
// Shared definitions for the host register path
// Terminal numbers, bus widths and memory port instruction codes
// Host request and response structs, memory port command and status structs
`default_nettype none

package terminal_pkg;

   // Bus widths
   localparam int DATA_W     = 32;
   localparam int TERM_W     = 16;
   localparam int REG_W      = 32;
   localparam int MEM_ADDR_W = 30;

   // Terminal numbers seen on the host side
   localparam logic [TERM_W-1:0] TERM_DRAM      = 16'd1;
   localparam logic [TERM_W-1:0] TERM_DRAM_CTRL = 16'd2;
   localparam logic [TERM_W-1:0] TERM_DUMMY     = 16'd3;

   localparam logic [DATA_W-1:0] DUMMY_WORD = 32'hBBAA9988;

   // Memory controller port instructions
   localparam logic [2:0] MEM_INSTR_WRITE = 3'd0;
   localparam logic [2:0] MEM_INSTR_READ  = 3'd1;

   // One host register access, strobes held until rdy
   typedef struct packed {
      logic [TERM_W-1:0] term_addr;
      logic [REG_W-1:0]  reg_addr;
      logic              read;
      logic              write;
      logic [DATA_W-1:0] data;
   } host_req_t;

   typedef struct packed {
      logic              rdy;
      logic [DATA_W-1:0] data;
   } host_rsp_t;

   // Signals driven towards the memory controller port
   typedef struct packed {
      logic                  cmd_en;
      logic [2:0]            instr;
      logic [MEM_ADDR_W-1:0] byte_addr;
      logic                  wr_en;
      logic [DATA_W-1:0]     wr_data;
      logic                  rd_en;
   } mem_cmd_t;

   // Signals coming back from the memory controller port
   typedef struct packed {
      logic              cmd_full;
      logic              wr_full;
      logic              rd_empty;
      logic [DATA_W-1:0] rd_data;
      logic              wr_error;
      logic              rd_overflow;
   } mem_status_t;

endpackage

`default_nettype wire
